// ==== verilog.f ====
+incdir+include
src/rv_pkg.sv
src/reg_port_if.sv
src/pipe_ctrl.sv
src/reg_file.sv
src/alu.sv
src/lsu_lanes.sv
src/rv_core.sv
verif/tb_rv_core.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_rv_core
FILELIST = verilog.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_rv_core.sv ====
`include "rv_settings.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    localparam int          RETIRE_TIMEOUT = 50;
    localparam int          MEM_WORDS      = 128;
    localparam logic [31:0] NOP            = 32'h0000_0033;

    // funct3 values for ALU operations and access sizes
    localparam logic [2:0] F3_ADD  = 3'd0;
    localparam logic [2:0] F3_SLL  = 3'd1;
    localparam logic [2:0] F3_SLT  = 3'd2;
    localparam logic [2:0] F3_SLTU = 3'd3;
    localparam logic [2:0] F3_XOR  = 3'd4;
    localparam logic [2:0] F3_SR   = 3'd5;
    localparam logic [2:0] F3_OR   = 3'd6;
    localparam logic [2:0] F3_AND  = 3'd7;
    localparam logic [2:0] SZ_B    = 3'd0;
    localparam logic [2:0] SZ_H    = 3'd1;
    localparam logic [2:0] SZ_W    = 3'd2;
    localparam logic [2:0] SZ_BU   = 3'd4;
    localparam logic [2:0] SZ_HU   = 3'd5;

    logic        clk;
    logic        rst;
    logic [31:0] imem_raddr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic        dmem_ren;
    logic        dmem_wen;
    logic [3:0]  dmem_mask;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wdata;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];

    // One program and expected retire entry per instruction
    logic [31:0] step_inst [$];
    logic [4:0]  step_rd [$];
    logic [31:0] step_value [$];
    bit          step_checked [$];
    int          step_test [$];

    // Expected data-memory writes in order
    int          store_test [$];
    logic [31:0] store_addr [$];
    logic [3:0]  store_mask [$];
    logic [31:0] store_data [$];

    // Expected data-memory reads in order
    int          load_test [$];
    logic [31:0] load_addr [$];

    string test_name [7];
    int    test_errors [7];
    int    stray_errors;
    int    tests_run;
    int    tests_failed;
    bit    timed_out;

    rv_core u_dut (
        .i_clk             (clk),
        .i_rst             (rst),
        .o_imem_raddr      (imem_raddr),
        .i_imem_rdata      (imem_rdata),
        .o_dmem_addr       (dmem_addr),
        .o_dmem_ren        (dmem_ren),
        .o_dmem_wen        (dmem_wen),
        .o_dmem_mask       (dmem_mask),
        .o_dmem_wdata      (dmem_wdata),
        .i_dmem_rdata      (dmem_rdata),
        .o_retire_valid    (retire_valid),
        .o_retire_pc       (retire_pc),
        .o_retire_rd_waddr (retire_rd),
        .o_retire_rd_wdata (retire_wdata)
    );

    always #10 clk = ~clk;

    //////////////////////////////
    // Memory models
    //////////////////////////////
    assign imem_rdata = imem[imem_raddr[8:2]];
    assign dmem_rdata = dmem[dmem_addr[8:2]];

    always @(posedge clk) begin
        if (dmem_wen) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_mask[b]) begin
                    dmem[dmem_addr[8:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // Encoding helpers
    //////////////////////////////
    function automatic logic [31:0] rr_inst(input logic [2:0] f3, input logic alt,
                                            input int rd, input int rs1, input int rs2);
        return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    // Also serves loads, which share the I-type layout
    function automatic logic [31:0] imm_inst(input opcode_t opc, input logic [2:0] f3,
                                             input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] store_inst(input logic [2:0] f3, input int rs2,
                                               input int rs1, input int imm);
        logic [11:0] im;
        im = 12'(imm);
        return {im[11:5], 5'(rs2), 5'(rs1), f3, im[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] lui_inst(input int rd, input int imm20);
        return {20'(imm20), 5'(rd), OPC_LUI};
    endfunction

    function automatic logic [31:0] lane_bits(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic add_step(input int test, input logic [31:0] inst, input int rd,
                            input logic [31:0] value, input bit checked);
        step_test.push_back(test);
        step_inst.push_back(inst);
        step_rd.push_back(5'(rd));
        step_value.push_back(value);
        step_checked.push_back(checked);
    endtask

    task automatic expect_store(input int test, input logic [31:0] addr,
                                input logic [3:0] mask, input logic [31:0] data);
        store_test.push_back(test);
        store_addr.push_back(addr);
        store_mask.push_back(mask);
        store_data.push_back(data);
    endtask

    task automatic expect_load(input int test, input logic [31:0] addr);
        load_test.push_back(test);
        load_addr.push_back(addr);
    endtask

    //////////////////////////////
    // Program and expected results
    //////////////////////////////
    task automatic load_program();
        add_step(2, imm_inst(OPC_OP_IMM, F3_ADD, 1, 0, 100), 1, 32'h0000_0064, 1);
        add_step(2, imm_inst(OPC_OP_IMM, F3_ADD, 2, 0, -7), 2, 32'hffff_fff9, 1);
        add_step(2, imm_inst(OPC_OP_IMM, F3_AND, 3, 2, 'h0f0), 3, 32'h0000_00f0, 1);
        add_step(2, imm_inst(OPC_OP_IMM, F3_OR, 4, 1, 'h700), 4, 32'h0000_0764, 1);
        add_step(2, imm_inst(OPC_OP_IMM, F3_XOR, 5, 1, -1), 5, 32'hffff_ff9b, 1);
        add_step(2, imm_inst(OPC_OP_IMM, F3_SLL, 6, 1, 4), 6, 32'h0000_0640, 1);
        add_step(2, imm_inst(OPC_OP_IMM, F3_SR, 7, 2, 28), 7, 32'h0000_000f, 1);
        // srai carries funct7 bit 5 in imm[10]
        add_step(2, imm_inst(OPC_OP_IMM, F3_SR, 8, 2, 'h402), 8, 32'hffff_fffe, 1);
        add_step(2, lui_inst(9, 'h12345), 9, 32'h1234_5000, 1);
        add_step(2, imm_inst(OPC_OP_IMM, F3_SLT, 10, 2, 0), 10, 32'h1, 1);
        add_step(2, imm_inst(OPC_OP_IMM, F3_SLTU, 11, 1, 200), 11, 32'h1, 1);

        add_step(3, rr_inst(F3_ADD, 1'b1, 12, 1, 4), 12, 32'hffff_f900, 1);
        add_step(3, rr_inst(F3_SLT, 1'b0, 13, 2, 1), 13, 32'h1, 1);
        add_step(3, rr_inst(F3_SLTU, 1'b0, 14, 2, 1), 14, 32'h0, 1);
        add_step(3, rr_inst(F3_SR, 1'b1, 15, 5, 7), 15, 32'hffff_ffff, 1);
        add_step(3, rr_inst(F3_SR, 1'b0, 16, 5, 7), 16, 32'h0001_ffff, 1);
        add_step(3, rr_inst(F3_ADD, 1'b0, 17, 1, 3), 17, 32'h0000_0154, 1);
        add_step(3, rr_inst(F3_AND, 1'b0, 18, 5, 4), 18, 32'h0000_0700, 1);
        add_step(3, rr_inst(F3_OR, 1'b0, 19, 3, 6), 19, 32'h0000_06f0, 1);
        add_step(3, rr_inst(F3_XOR, 1'b0, 20, 4, 6), 20, 32'h0000_0124, 1);
        add_step(3, rr_inst(F3_SLL, 1'b0, 21, 1, 7), 21, 32'h0032_0000, 1);
        add_step(3, rr_inst(F3_ADD, 1'b0, 0, 1, 2), 0, 32'h0, 0);
        add_step(3, rr_inst(F3_ADD, 1'b0, 22, 0, 0), 22, 32'h0, 1);

        // Distances 1, 2 and 3 to the producing instruction
        add_step(4, imm_inst(OPC_OP_IMM, F3_ADD, 23, 0, 5), 23, 32'd5, 1);
        add_step(4, imm_inst(OPC_OP_IMM, F3_ADD, 24, 23, 3), 24, 32'd8, 1);
        add_step(4, rr_inst(F3_ADD, 1'b0, 25, 24, 23), 25, 32'd13, 1);
        add_step(4, imm_inst(OPC_OP_IMM, F3_SLL, 26, 25, 2), 26, 32'd52, 1);
        add_step(4, rr_inst(F3_ADD, 1'b1, 27, 26, 24), 27, 32'd44, 1);
        add_step(4, rr_inst(F3_ADD, 1'b0, 28, 27, 25), 28, 32'd57, 1);

        add_step(5, imm_inst(OPC_OP_IMM, F3_ADD, 29, 0, 'h100), 29, 32'h0000_0100, 1);
        add_step(5, imm_inst(OPC_OP_IMM, F3_ADD, 30, 9, 'h678), 30, 32'h1234_5678, 1);
        add_step(5, store_inst(SZ_W, 30, 29, 4), 0, 32'h0, 0);
        add_step(5, imm_inst(OPC_LOAD, SZ_W, 31, 29, 4), 31, 32'h1234_5678, 1);
        expect_store(5, 32'h0000_0104, 4'b1111, 32'h1234_5678);
        expect_load(5, 32'h0000_0104);

        // Byte 3 first, so the half store leaves 16'hf900 in the upper pair
        add_step(6, store_inst(SZ_B, 1, 29, 11), 0, 32'h0, 0);
        add_step(6, store_inst(SZ_B, 5, 29, 9), 0, 32'h0, 0);
        add_step(6, store_inst(SZ_H, 12, 29, 10), 0, 32'h0, 0);
        add_step(6, imm_inst(OPC_LOAD, SZ_B, 10, 29, 9), 10, 32'hffff_ff9b, 1);
        add_step(6, imm_inst(OPC_LOAD, SZ_BU, 11, 29, 9), 11, 32'h0000_009b, 1);
        add_step(6, imm_inst(OPC_LOAD, SZ_H, 13, 29, 10), 13, 32'hffff_f900, 1);
        add_step(6, imm_inst(OPC_LOAD, SZ_HU, 14, 29, 10), 14, 32'h0000_f900, 1);
        add_step(6, imm_inst(OPC_LOAD, SZ_B, 15, 29, 11), 15, 32'hffff_fff9, 1);
        expect_store(6, 32'h0000_0108, 4'b1000, 32'h6400_0000);
        expect_store(6, 32'h0000_0108, 4'b0010, 32'h0000_9b00);
        expect_store(6, 32'h0000_0108, 4'b1100, 32'hf900_0000);
        repeat (5) begin
            expect_load(6, 32'h0000_0108);
        end
    endtask

    //////////////////////////////
    // Checking
    //////////////////////////////
    task automatic compare_field(input int test, input string name,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            test_errors[test]++;
        end
    endtask

    task automatic report_test(input int test);
        tests_run++;
        if (test_errors[test] != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s, %0d errors", test, test_name[test],
                 (test_errors[test] == 0) ? "ok" : "failed", test_errors[test]);
    endtask

    task automatic wait_retire(output bit seen);
        int waited;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < RETIRE_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (retire_valid === 1'b1) begin
                seen = 1'b1;
            end
        end
    endtask

    // Data port strobes sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && dmem_wen === 1'b1) begin
            if (store_addr.size() == 0) begin
                $display("Unexpected store to %h at %0t ns", dmem_addr, $time);
                stray_errors++;
            end else begin
                compare_field(store_test[0], "o_dmem_addr", store_addr[0], dmem_addr);
                compare_field(store_test[0], "o_dmem_mask", {28'b0, store_mask[0]},
                              {28'b0, dmem_mask});
                compare_field(store_test[0], "o_dmem_wdata", store_data[0],
                              dmem_wdata & lane_bits(dmem_mask));
                void'(store_test.pop_front());
                void'(store_addr.pop_front());
                void'(store_mask.pop_front());
                void'(store_data.pop_front());
            end
        end
        if (!rst && dmem_ren === 1'b1) begin
            if (load_addr.size() == 0) begin
                $display("Unexpected load from %h at %0t ns", dmem_addr, $time);
                stray_errors++;
            end else begin
                compare_field(load_test[0], "o_dmem_addr", load_addr[0], dmem_addr);
                void'(load_test.pop_front());
                void'(load_addr.pop_front());
            end
        end
    end

    initial begin
        bit seen;
        int total;
        clk = 1'b0;
        rst = 1'b1;
        timed_out = 1'b0;
        stray_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_name[1] = "reset state";
        test_name[2] = "immediate and LUI";
        test_name[3] = "register-register";
        test_name[4] = "dependent chain";
        test_name[5] = "word store and load";
        test_name[6] = "sub-word access";
        load_program();
        for (int w = 0; w < MEM_WORDS; w++) begin
            imem[w] = NOP;
            dmem[w] = 32'h5a00_0000 ^ (w << 2);
        end
        for (int i = 0; i < step_inst.size(); i++) begin
            imem[i] = step_inst[i];
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        compare_field(1, "o_retire_valid", 32'h0, {31'b0, retire_valid});
        compare_field(1, "o_dmem_ren", 32'h0, {31'b0, dmem_ren});
        compare_field(1, "o_dmem_wen", 32'h0, {31'b0, dmem_wen});
        compare_field(1, "o_imem_raddr", `RV_RESET_ADDR, imem_raddr);
        report_test(1);

        // Retires arrive in program order at consecutive pcs
        for (int i = 0; i < step_inst.size() && !timed_out; i++) begin
            wait_retire(seen);
            if (!seen) begin
                $display("Timeout: no instruction retired within %0d cycles", RETIRE_TIMEOUT);
                test_errors[step_test[i]]++;
                timed_out = 1'b1;
            end else begin
                compare_field(step_test[i], "o_retire_pc", `RV_RESET_ADDR + 32'(4 * i),
                              retire_pc);
                compare_field(step_test[i], "o_retire_rd_waddr", {27'b0, step_rd[i]},
                              {27'b0, retire_rd});
                if (step_checked[i]) begin
                    compare_field(step_test[i], "o_retire_rd_wdata", step_value[i],
                                  retire_wdata);
                end
            end
            if (timed_out || i == step_inst.size() - 1 || step_test[i + 1] != step_test[i]) begin
                report_test(step_test[i]);
            end
        end

        if (store_addr.size() != 0) begin
            $display("Missing stores: %0d expected writes never reached the data port",
                     store_addr.size());
            stray_errors++;
        end
        if (load_addr.size() != 0) begin
            $display("Missing loads: %0d expected reads never reached the data port",
                     load_addr.size());
            stray_errors++;
        end

        total = stray_errors;
        for (int t = 1; t <= 6; t++) begin
            total += test_errors[t];
        end
        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total);
        if (total == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src/rv_core.sv ====
`include "rv_settings.svh"

module rv_core (
    input  logic                  i_clk,
    input  logic                  i_rst,
    output logic [`RV_XLEN-1:0]   o_imem_raddr,
    input  logic [`RV_XLEN-1:0]   i_imem_rdata,
    output logic [`RV_XLEN-1:0]   o_dmem_addr,
    output logic                  o_dmem_ren,
    output logic                  o_dmem_wen,
    output logic [3:0]            o_dmem_mask,
    output logic [`RV_XLEN-1:0]   o_dmem_wdata,
    input  logic [`RV_XLEN-1:0]   i_dmem_rdata,
    output logic                  o_retire_valid,
    output logic [`RV_XLEN-1:0]   o_retire_pc,
    output logic [`RV_REG_AW-1:0] o_retire_rd_waddr,
    output logic [`RV_XLEN-1:0]   o_retire_rd_wdata
);
    import rv_pkg::*;

    localparam int XLEN = `RV_XLEN;

    reg_port_if #(.AW(`RV_REG_AW), .DW(`RV_XLEN)) rf_port ();

    logic            stall;
    logic [XLEN-1:0] pc;
    logic            if_id_valid;
    logic [XLEN-1:0] if_id_pc;
    logic [XLEN-1:0] if_id_inst;
    id_ctrl_t        id_ctrl;
    logic [XLEN-1:0] id_imm;
    logic            id_ex_valid;
    id_ctrl_t        id_ex_ctrl;
    logic [XLEN-1:0] id_ex_pc;
    logic [XLEN-1:0] id_ex_imm;
    logic [XLEN-1:0] id_ex_rs1;
    logic [XLEN-1:0] id_ex_rs2;
    logic [XLEN-1:0] ex_op_b;
    logic [XLEN-1:0] ex_result;
    logic            ex_mem_valid;
    id_ctrl_t        ex_mem_ctrl;
    logic [XLEN-1:0] ex_mem_pc;
    logic [XLEN-1:0] ex_mem_result;
    logic [XLEN-1:0] ex_mem_store;
    logic [XLEN-1:0] mem_load_data;
    logic            mem_wb_valid;
    id_ctrl_t        mem_wb_ctrl;
    logic [XLEN-1:0] mem_wb_pc;
    logic [XLEN-1:0] mem_wb_result;
    logic [XLEN-1:0] mem_wb_load;
    logic [XLEN-1:0] wb_wdata;

    //////////////////////////////
    // IF
    //////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc          <= `RV_RESET_ADDR;
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            pc          <= pc + 4;
            if_id_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!stall) begin
            if_id_pc   <= pc;
            if_id_inst <= i_imem_rdata;
        end
    end

    assign o_imem_raddr = pc;

    //////////////////////////////
    // ID
    //////////////////////////////
    pipe_ctrl u_ctrl (
        .i_inst      (if_id_inst),
        .i_ex_ctrl   (id_ex_ctrl),
        .i_mem_ctrl  (ex_mem_ctrl),
        .i_ex_valid  (id_ex_valid),
        .i_mem_valid (ex_mem_valid),
        .rf          (rf_port.reader),
        .o_ctrl      (id_ctrl),
        .o_imm       (id_imm),
        .o_stall     (stall)
    );

    reg_file u_rf (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .rf    (rf_port.file)
    );

    // A stall turns the ID/EX slot into a bubble
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            id_ex_valid <= 1'b0;
        end else begin
            id_ex_valid <= if_id_valid && !stall;
        end
    end

    // Producer leaves MEM within two cycles, so the stall must drop by then
    assert property (@(posedge i_clk) disable iff (i_rst)
        stall && $past(stall) |=> !stall)
        else $error("stall held for more than two cycles");

    always_ff @(posedge i_clk) begin
        id_ex_ctrl <= id_ctrl;
        id_ex_pc   <= if_id_pc;
        id_ex_imm  <= id_imm;
        id_ex_rs1  <= rf_port.rs1_data;
        id_ex_rs2  <= rf_port.rs2_data;
    end

    //////////////////////////////
    // EX
    //////////////////////////////
    assign ex_op_b = id_ex_ctrl.use_imm ? id_ex_imm : id_ex_rs2;

    alu u_alu (
        .i_op     (id_ex_ctrl.alu_op),
        .i_a      (id_ex_rs1),
        .i_b      (ex_op_b),
        .o_result (ex_result)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ex_mem_valid <= 1'b0;
        end else begin
            ex_mem_valid <= id_ex_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        ex_mem_ctrl   <= id_ex_ctrl;
        ex_mem_pc     <= id_ex_pc;
        ex_mem_result <= ex_result;
        ex_mem_store  <= id_ex_rs2;
    end

    //////////////////////////////
    // MEM
    //////////////////////////////
    lsu_lanes u_lsu (
        .i_addr_lo    (ex_mem_result[1:0]),
        .i_size       (ex_mem_ctrl.mem_size),
        .i_unsigned   (ex_mem_ctrl.load_unsigned),
        .i_store_data (ex_mem_store),
        .i_load_word  (i_dmem_rdata),
        .o_mask       (o_dmem_mask),
        .o_wdata      (o_dmem_wdata),
        .o_load_data  (mem_load_data)
    );

    assign o_dmem_addr = {ex_mem_result[XLEN-1:2], 2'b00};
    assign o_dmem_ren  = ex_mem_valid && ex_mem_ctrl.mem_read;
    assign o_dmem_wen  = ex_mem_valid && ex_mem_ctrl.mem_write;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mem_wb_valid <= 1'b0;
        end else begin
            mem_wb_valid <= ex_mem_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        mem_wb_ctrl   <= ex_mem_ctrl;
        mem_wb_pc     <= ex_mem_pc;
        mem_wb_result <= ex_mem_result;
        mem_wb_load   <= mem_load_data;
    end

    //////////////////////////////
    // WB and retire
    //////////////////////////////
    assign wb_wdata = mem_wb_ctrl.mem_read ? mem_wb_load : mem_wb_result;

    assign rf_port.we    = mem_wb_valid && mem_wb_ctrl.reg_write;
    assign rf_port.waddr = mem_wb_ctrl.rd;
    assign rf_port.wdata = wb_wdata;

    assign o_retire_valid    = mem_wb_valid;
    assign o_retire_pc       = mem_wb_pc;
    assign o_retire_rd_waddr = mem_wb_ctrl.rd;
    assign o_retire_rd_wdata = wb_wdata;

endmodule

// ==== src/lsu_lanes.sv ====
`include "rv_settings.svh"

module lsu_lanes (
    input  logic [1:0]            i_addr_lo,
    input  rv_pkg::mem_size_t     i_size,
    input  logic                  i_unsigned,
    input  logic [`RV_XLEN-1:0]   i_store_data,
    input  logic [`RV_XLEN-1:0]   i_load_word,
    output logic [3:0]            o_mask,
    output logic [`RV_XLEN-1:0]   o_wdata,
    output logic [`RV_XLEN-1:0]   o_load_data
);
    import rv_pkg::*;

    localparam int XLEN = `RV_XLEN;

    logic [4:0]      byte_shift;
    logic [4:0]      half_shift;
    logic [XLEN-1:0] byte_word;
    logic [XLEN-1:0] half_word;

    // Bit offsets of the addressed byte and half
    assign byte_shift = {i_addr_lo, 3'b000};
    assign half_shift = {i_addr_lo[1], 4'b0000};

    //////////////////////////////
    // Store side
    //////////////////////////////
    always_comb begin
        case (i_size)
            MEM_BYTE: begin
                o_mask  = 4'b0001 << i_addr_lo;
                o_wdata = i_store_data << byte_shift;
            end
            MEM_HALF: begin
                o_mask  = i_addr_lo[1] ? 4'b1100 : 4'b0011;
                o_wdata = i_store_data << half_shift;
            end
            default: begin
                o_mask  = 4'b1111;
                o_wdata = i_store_data;
            end
        endcase
    end

    //////////////////////////////
    // Load side
    //////////////////////////////
    assign byte_word = i_load_word >> byte_shift;
    assign half_word = i_load_word >> half_shift;

    always_comb begin
        case (i_size)
            MEM_BYTE: begin
                o_load_data = {{(XLEN-8){~i_unsigned & byte_word[7]}}, byte_word[7:0]};
            end
            MEM_HALF: begin
                o_load_data = {{(XLEN-16){~i_unsigned & half_word[15]}}, half_word[15:0]};
            end
            default: o_load_data = i_load_word;
        endcase
    end

endmodule

// ==== src/alu.sv ====
`include "rv_settings.svh"

module alu (
    input  rv_pkg::alu_op_t     i_op,
    input  logic [`RV_XLEN-1:0] i_a,
    input  logic [`RV_XLEN-1:0] i_b,
    output logic [`RV_XLEN-1:0] o_result
);
    import rv_pkg::*;

    localparam int XLEN = `RV_XLEN;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = i_b[4:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:    o_result = i_a << shamt;
            ALU_SRL:    o_result = i_a >> shamt;
            ALU_SRA:    o_result = $signed(i_a) >>> shamt;
            ALU_PASS_B: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
`include "rv_settings.svh"

module reg_file (
    input  logic     i_clk,
    input  logic     i_rst,
    reg_port_if.file rf
);
    localparam int XLEN = `RV_XLEN;

    logic [XLEN-1:0] regs [`RV_NUM_REGS];
    logic            wr_live;

    // x0 is never written
    assign wr_live = rf.we && rf.waddr != '0;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // WB write shows up on same-cycle reads
    assign rf.rs1_data = (wr_live && rf.waddr == rf.rs1_addr) ? rf.wdata : regs[rf.rs1_addr];
    assign rf.rs2_data = (wr_live && rf.waddr == rf.rs2_addr) ? rf.wdata : regs[rf.rs2_addr];

endmodule

// ==== src/pipe_ctrl.sv ====
`include "rv_settings.svh"

module pipe_ctrl (
    input  logic [`RV_XLEN-1:0] i_inst,
    input  rv_pkg::id_ctrl_t    i_ex_ctrl,
    input  rv_pkg::id_ctrl_t    i_mem_ctrl,
    input  logic                i_ex_valid,
    input  logic                i_mem_valid,
    reg_port_if.reader          rf,
    output rv_pkg::id_ctrl_t    o_ctrl,
    output logic [`RV_XLEN-1:0] o_imm,
    output logic                o_stall
);
    import rv_pkg::*;

    localparam int XLEN = `RV_XLEN;
    localparam int AW   = `RV_REG_AW;

    opcode_t       opcode;
    logic [2:0]    funct3;
    logic          funct7_b5;
    logic [AW-1:0] rs1;
    logic [AW-1:0] rs2;
    logic          uses_rs1;
    logic          uses_rs2;

    assign opcode    = opcode_t'(i_inst[6:0]);
    assign funct3    = i_inst[14:12];
    assign funct7_b5 = i_inst[30];
    assign rs1       = i_inst[19:15];
    assign rs2       = i_inst[24:20];

    assign rf.rs1_addr = rs1;
    assign rf.rs2_addr = rs2;

    function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    //////////////////////////////
    // Instruction decode
    //////////////////////////////
    always_comb begin
        o_ctrl   = '0;
        o_imm    = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                o_ctrl.alu_op    = funct_to_alu(funct3, funct7_b5);
                o_ctrl.reg_write = 1'b1;
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
            end
            OPC_OP_IMM: begin
                // No subi so funct7 only selects sra
                o_ctrl.alu_op    = funct_to_alu(funct3, funct3 == 3'b101 && funct7_b5);
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                uses_rs1         = 1'b1;
            end
            OPC_LUI: begin
                o_ctrl.alu_op    = ALU_PASS_B;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_imm            = {i_inst[31:12], 12'b0};
            end
            OPC_LOAD: begin
                o_ctrl.alu_op        = ALU_ADD;
                o_ctrl.use_imm       = 1'b1;
                o_ctrl.reg_write     = 1'b1;
                o_ctrl.mem_read      = 1'b1;
                o_ctrl.mem_size      = mem_size_t'(funct3[1:0]);
                o_ctrl.load_unsigned = funct3[2];
                uses_rs1             = 1'b1;
            end
            OPC_STORE: begin
                o_ctrl.alu_op    = ALU_ADD;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.mem_write = 1'b1;
                o_ctrl.mem_size  = mem_size_t'(funct3[1:0]);
                o_imm            = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
            end
            default: ;
        endcase
        // Unknown opcodes and stores report rd 0
        o_ctrl.rd = o_ctrl.reg_write ? i_inst[11:7] : '0;
    end

    //////////////////////////////
    // Read-after-write stall
    //////////////////////////////
    function automatic logic pending(input logic [AW-1:0] rs);
        logic ex_hit;
        logic mem_hit;
        ex_hit  = i_ex_valid && i_ex_ctrl.reg_write && i_ex_ctrl.rd == rs;
        mem_hit = i_mem_valid && i_mem_ctrl.reg_write && i_mem_ctrl.rd == rs;
        return rs != '0 && (ex_hit || mem_hit);
    endfunction

    always_comb begin
        o_stall = (uses_rs1 && pending(rs1)) || (uses_rs2 && pending(rs2));
    end

endmodule

// ==== src/reg_port_if.sv ====
`include "rv_settings.svh"

interface reg_port_if #(
    parameter int AW = `RV_REG_AW,
    parameter int DW = `RV_XLEN
);
    logic [AW-1:0] rs1_addr;
    logic [AW-1:0] rs2_addr;
    logic [DW-1:0] rs1_data;
    logic [DW-1:0] rs2_data;

    // Write port, fed from WB
    logic          we;
    logic [AW-1:0] waddr;
    logic [DW-1:0] wdata;

    modport file (input rs1_addr, rs2_addr, we, waddr, wdata, output rs1_data, rs2_data);
    modport reader (output rs1_addr, rs2_addr);
    modport writer (output we, waddr, wdata, input rs1_data, rs2_data);
endinterface

// ==== src/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B  // LUI result is the immediate
    } alu_op_t;

    // Same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_t;

    typedef struct packed {
        alu_op_t                alu_op;
        logic                   use_imm;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        mem_size_t              mem_size;
        logic                   load_unsigned;
        logic [`RV_REG_AW-1:0]  rd;
    } id_ctrl_t;

endpackage

// ==== include/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path and address width
`define RV_XLEN 32

// Register file geometry
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// First fetch address after reset
`define RV_RESET_ADDR 32'h0000_0000

`endif
